/* Bender.yml */
package:
  name: sa_accel

sources:
  - rtl/sa_geom_pkg.sv
  - rtl/sa_stream_pkg.sv
  - rtl/sa_skid_buffer.sv
  - rtl/sa_stream_join.sv
  - rtl/sa_mac_row.sv
  - rtl/sa_drain.sv
  - rtl/sa_top.sv
  - target: simulation
    files:
      - bench/sa_top_sva.sv
      - bench/tb_sa_top.sv

/* bench/sa_top_sva.sv */
`default_nettype none

module sa_top_sva (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      pix_valid,
  input logic                      pix_ready,
  input sa_stream_pkg::pix_beat_t  pix_data,
  input logic                      wgt_valid,
  input logic                      wgt_ready,
  input sa_stream_pkg::wgt_beat_t  wgt_data,
  input logic                      psum_valid,
  input logic                      psum_ready,
  input sa_stream_pkg::psum_beat_t psum_data,
  input logic                      out_valid,
  input logic                      out_ready,
  input sa_stream_pkg::out_beat_t  out_data
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned           fail_cnt = 0;
  sa_geom_pkg::col_idx_t beat_q;

  // Position of the next output beat within its tile
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_q <= '0;
    end else if (out_valid && out_ready) begin
      if (beat_q == sa_geom_pkg::col_idx_t'(sa_geom_pkg::C - 1)) begin
        beat_q <= '0;
      end else begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  pix_hold: assert property (@(posedge clk) disable iff (!rst_n)
    pix_valid && !pix_ready |=> pix_valid && $stable(pix_data))
    else begin $error("pixel beat changed while stalled"); fail_cnt++; end

  wgt_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wgt_valid && !wgt_ready |=> wgt_valid && $stable(wgt_data))
    else begin $error("weight beat changed while stalled"); fail_cnt++; end

  psum_hold: assert property (@(posedge clk) disable iff (!rst_n)
    psum_valid && !psum_ready |=> psum_valid && $stable(psum_data))
    else begin $error("partial-sum beat changed while stalled"); fail_cnt++; end

  out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin $error("output beat changed while stalled"); fail_cnt++; end

  out_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else begin $error("out_valid high during reset"); fail_cnt++; end

  // Last flag on every C-th beat and nowhere else
  out_last_pos: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> out_data.last == (beat_q == sa_geom_pkg::col_idx_t'(sa_geom_pkg::C - 1)))
    else begin $error("output last flag on wrong beat"); fail_cnt++; end

endmodule

bind sa_top sa_top_sva u_sva (.*);

`default_nettype wire

/* bench/tb_sa_top.sv */
`default_nettype none

module tb_sa_top;

  timeunit 1ns;
  timeprecision 1ps;

  logic                      clk;
  logic                      rst_n;
  logic                      pix_valid;
  logic                      pix_ready;
  sa_stream_pkg::pix_beat_t  pix_data;
  logic                      wgt_valid;
  logic                      wgt_ready;
  sa_stream_pkg::wgt_beat_t  wgt_data;
  logic                      psum_valid;
  logic                      psum_ready;
  sa_stream_pkg::psum_beat_t psum_data;
  logic                      out_valid;
  logic                      out_ready;
  sa_stream_pkg::out_beat_t  out_data;

  logic [31:0]               seed = 32'h402c_5163;
  int                        max_wait = 1000;
  string                     test_name;

  // Stimulus and expected beats, in stream order
  sa_stream_pkg::pix_beat_t  pix_q[$];
  sa_stream_pkg::wgt_beat_t  wgt_q[$];
  sa_stream_pkg::psum_beat_t psum_q[$];
  sa_stream_pkg::out_beat_t  exp_q[$];
  int                        pix_gap_q[$];
  int                        wgt_gap_q[$];

  sa_top dut0 (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int pick(input int n);
    logic [31:0] w;
    w = next_random();
    return int'(w[31:8] % n);
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  // kind 0 fixed ramps, kind 1 extreme operands, kind 2 random with gaps
  task automatic add_tile(input int len, input int kind);
    sa_stream_pkg::pix_beat_t  pb;
    sa_stream_pkg::wgt_beat_t  wb;
    sa_stream_pkg::psum_beat_t sb;
    sa_stream_pkg::out_beat_t  ob;
    sa_geom_pkg::acc_t         acc [sa_geom_pkg::R][sa_geom_pkg::C];
    for (int i = 0; i < len; i++) begin
      for (int r = 0; r < sa_geom_pkg::R; r++) begin
        case (kind)
          0:       pb.pix[r] = sa_geom_pkg::pix_t'(3 * r + i - 4);
          1:       pb.pix[r] = sa_geom_pkg::pix_t'((pick(2) == 0) ? -128 : 127);
          default: pb.pix[r] = sa_geom_pkg::pix_t'(pick(256));
        endcase
      end
      for (int c = 0; c < sa_geom_pkg::C; c++) begin
        case (kind)
          0:       wb.wgt[c] = sa_geom_pkg::wgt_t'(7 - 2 * c - i);
          1:       wb.wgt[c] = sa_geom_pkg::wgt_t'((pick(2) == 0) ? -128 : 127);
          default: wb.wgt[c] = sa_geom_pkg::wgt_t'(pick(256));
        endcase
      end
      pb.last = (i == len - 1);
      wb.last = pb.last;
      // Outer product, first beat of a tile starts from zero
      for (int r = 0; r < sa_geom_pkg::R; r++) begin
        for (int c = 0; c < sa_geom_pkg::C; c++) begin
          acc[r][c] = ((i == 0) ? 0 : acc[r][c]) + $signed(pb.pix[r]) * $signed(wb.wgt[c]);
        end
      end
      pix_q.push_back(pb);
      wgt_q.push_back(wb);
      pix_gap_q.push_back((kind == 2 && pick(3) == 0) ? pick(5) : 0);
      wgt_gap_q.push_back((kind == 2 && pick(3) == 0) ? pick(5) : 0);
    end
    for (int c = 0; c < sa_geom_pkg::C; c++) begin
      for (int r = 0; r < sa_geom_pkg::R; r++) begin
        case (kind)
          0:       sb.psum[r] = sa_geom_pkg::psum_t'(1000 * r - 7 * c);
          1:       sb.psum[r] = sa_geom_pkg::psum_t'((r % 2 == 0) ? 32'h7fff_ff00 + pick(256)
                                                               : 32'h8000_0000 - pick(256));
          default: sb.psum[r] = sa_geom_pkg::psum_t'(next_random());
        endcase
        // Partial sum cut to the output width, sum wraps modulo 2^WY
        ob.data[r] = acc[r][c] + sa_geom_pkg::acc_t'(sb.psum[r][sa_geom_pkg::WY-1:0]);
      end
      ob.last = (c == sa_geom_pkg::C - 1);
      psum_q.push_back(sb);
      exp_q.push_back(ob);
    end
  endtask

  task automatic pix_source();
    int waited;
    while (pix_q.size() > 0) begin
      repeat (pix_gap_q.pop_front()) @(negedge clk);
      pix_data  = pix_q.pop_front();
      pix_valid = 1'b1;
      waited = 0;
      // Ready is registered, the value seen here holds at the next rising edge
      while (!pix_ready) begin
        @(negedge clk);
        waited++;
        if (waited > max_wait) fail_run("pixel beat was never accepted");
      end
      @(negedge clk);
      pix_valid = 1'b0;
    end
  endtask

  task automatic wgt_source(input int delay);
    int waited;
    if (delay > 0) begin
      repeat (delay) @(negedge clk);
      assert (!pix_ready)
        else fail_run("pixel stream kept moving while the weight stream was idle");
    end
    while (wgt_q.size() > 0) begin
      repeat (wgt_gap_q.pop_front()) @(negedge clk);
      wgt_data  = wgt_q.pop_front();
      wgt_valid = 1'b1;
      waited = 0;
      while (!wgt_ready) begin
        @(negedge clk);
        waited++;
        if (waited > max_wait) fail_run("weight beat was never accepted");
      end
      @(negedge clk);
      wgt_valid = 1'b0;
    end
  endtask

  task automatic psum_source();
    int waited;
    while (psum_q.size() > 0) begin
      psum_data  = psum_q.pop_front();
      psum_valid = 1'b1;
      waited = 0;
      while (!psum_ready) begin
        @(negedge clk);
        waited++;
        if (waited > max_wait) fail_run("partial-sum beat was never accepted");
      end
      @(negedge clk);
      psum_valid = 1'b0;
    end
  endtask

  // Stretches of low out_ready when stall is set
  task automatic out_sink(input int n, input bit stall);
    sa_stream_pkg::out_beat_t exp;
    int got;
    int idle;
    int hold;
    got = 0;
    idle = 0;
    hold = 0;
    while (got < n) begin
      @(negedge clk);
      if (stall && hold == 0) begin
        out_ready = (pick(3) != 0);
        hold = 1 + pick(16);
      end else if (!stall) begin
        out_ready = 1'b1;
      end
      if (hold > 0) hold--;
      // Beat seen here moves on the next rising edge
      if (out_valid && out_ready) begin
        exp = exp_q.pop_front();
        assert (out_data == exp)
          else fail_run($sformatf("Fail %s beat %0d: expected %h, actual %h",
                                  test_name, got, exp, out_data));
        got++;
        idle = 0;
      end else begin
        idle++;
        if (idle > max_wait) fail_run("output beat did not arrive in time");
      end
    end
    @(negedge clk);
    out_ready = 1'b0;
  endtask

  task automatic run_phase(input string name, input bit stall, input int delay);
    int n;
    test_name = name;
    n = exp_q.size();
    fork
      pix_source();
      wgt_source(delay);
      psum_source();
      out_sink(n, stall);
    join
  endtask

  always @(negedge clk) begin
    if (dut0.u_sva.fail_cnt != 0) fail_run("a protocol assertion on the top-level streams failed");
  end

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    pix_valid  = 1'b0;
    pix_data   = '0;
    wgt_valid  = 1'b0;
    wgt_data   = '0;
    psum_valid = 1'b0;
    psum_data  = '0;
    out_ready  = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    test_name = "idle";
    repeat (8) begin
      @(negedge clk);
      assert (!out_valid && !psum_ready && pix_ready && wgt_ready)
        else fail_run("stream handshakes are not idle after reset");
    end

    add_tile(5, 0);
    run_phase("single_tile", 1'b0, 0);
    for (int t = 0; t < 3; t++) add_tile(1, 1);
    run_phase("extreme_wrap", 1'b0, 0);
    for (int t = 0; t < 20; t++) add_tile(1 + pick(8), 2);
    run_phase("random_tiles", 1'b1, 0);
    add_tile(6, 0);
    run_phase("weight_idle", 1'b0, 16);

    @(negedge clk);
    if (dut0.u_sva.fail_cnt == 0 && !out_valid) begin
      $display("Simulation PASSED");
    end else begin
      fail_run("a stray output beat or a failed protocol assertion at the end of the run");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/sa_drain.sv */
`default_nettype none

module sa_drain (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       tile_end,
  input  sa_geom_pkg::acc_row_t      row_acc [sa_geom_pkg::R],
  output logic                       tile_free,

  input  logic                       psum_valid,
  output logic                       psum_ready,
  input  sa_stream_pkg::psum_beat_t  psum_data,

  output logic                       out_valid,
  input  logic                       out_ready,
  output sa_stream_pkg::out_beat_t   out_data
);

  sa_geom_pkg::acc_row_t tile_q [sa_geom_pkg::R];
  logic                  buf_valid_q;
  sa_geom_pkg::col_idx_t col_q;
  logic                  last_col;
  logic                  col_fire;

  assign last_col = (col_q == sa_geom_pkg::col_idx_t'(sa_geom_pkg::C - 1));

  // Column joined with one partial-sum beat
  assign out_valid  = buf_valid_q & psum_valid;
  assign psum_ready = buf_valid_q & out_ready;
  assign col_fire   = out_valid & out_ready;

  // Busy from the capture cycle until the last column leaves
  assign tile_free = ~buf_valid_q & ~tile_end;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      buf_valid_q <= 1'b0;
      col_q       <= '0;
    end else if (tile_end) begin
      buf_valid_q <= 1'b1;
      col_q       <= '0;
    end else if (col_fire) begin
      if (last_col) begin
        buf_valid_q <= 1'b0;
        col_q       <= '0;
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  // Snapshot of all rows, rows are free to start the next tile
  always_ff @(posedge clk) begin
    if (tile_end) begin
      tile_q <= row_acc;
    end
  end

  // Partial sum cut to WY bits, sum wraps modulo 2^WY
  always_comb begin
    out_data.last = last_col;
    for (int r = 0; r < sa_geom_pkg::R; r++) begin
      out_data.data[r] = $signed(tile_q[r][col_q])
                       + $signed(psum_data.psum[r][sa_geom_pkg::WY-1:0]);
    end
  end

endmodule

`default_nettype wire

/* rtl/sa_geom_pkg.sv */
`default_nettype none

package sa_geom_pkg;

  // Array shape
  localparam int unsigned R = 4;
  localparam int unsigned C = 4;

  // Operand widths
  localparam int unsigned WX = 8;
  localparam int unsigned WK = 8;
  localparam int unsigned WY = 32;
  localparam int unsigned WA = 32;

  // Element types
  typedef logic signed [WX-1:0] pix_t;
  typedef logic signed [WK-1:0] wgt_t;
  typedef logic signed [WY-1:0] acc_t;
  typedef logic signed [WA-1:0] psum_t;

  // Finished results of one row, one accumulator per column
  typedef acc_t [C-1:0] acc_row_t;

  // Column counter of the drain
  typedef logic [$clog2(C)-1:0] col_idx_t;

endpackage

`default_nettype wire

/* rtl/sa_mac_row.sv */
`default_nettype none

module sa_mac_row #(
  parameter int unsigned ROW = 0
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  step_en,
  input  sa_stream_pkg::step_t  step,

  output sa_geom_pkg::acc_row_t acc
);

  sa_geom_pkg::acc_t prod [sa_geom_pkg::C];
  logic              first_q;

  // This row's pixel against every weight of the beat
  always_comb begin
    for (int c = 0; c < sa_geom_pkg::C; c++) begin
      prod[c] = $signed(step.pix[ROW]) * $signed(step.wgt[c]);
    end
  end

  // Set after reset and after a last step, so the next tile starts clean
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_q <= 1'b1;
    end else if (step_en) begin
      first_q <= step.last;
    end
  end

  // Results stay put between steps for the drain to pick up
  always_ff @(posedge clk) begin
    if (step_en) begin
      for (int c = 0; c < sa_geom_pkg::C; c++) begin
        if (first_q) begin
          acc[c] <= prod[c];
        end else begin
          acc[c] <= acc[c] + prod[c];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/sa_skid_buffer.sv */
`default_nettype none

module sa_skid_buffer #(
  parameter type beat_t = logic [7:0]
) (
  input  logic  clk,
  input  logic  rst_n,

  input  logic  in_valid,
  output logic  in_ready,
  input  beat_t in_data,

  output logic  out_valid,
  input  logic  out_ready,
  output beat_t out_data
);

  logic  skid_valid_q;
  beat_t skid_data_q;
  logic  in_fire;
  logic  out_free;

  // Output register may take a new beat this cycle
  assign out_free = ~out_valid | out_ready;
  assign in_fire  = in_valid & in_ready;

  // Ready comes straight from the skid flag
  assign in_ready = ~skid_valid_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid    <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (out_free) begin
      out_valid    <= skid_valid_q | in_fire;
      skid_valid_q <= 1'b0;
    end else if (in_fire) begin
      // Output stalled, park the beat
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      // Skid entry is older than anything on the input
      if (skid_valid_q) begin
        out_data <= skid_data_q;
      end else begin
        out_data <= in_data;
      end
    end
    if (!out_free && in_fire) begin
      skid_data_q <= in_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/sa_stream_join.sv */
`default_nettype none

module sa_stream_join (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      pix_valid,
  output logic                      pix_ready,
  input  sa_stream_pkg::pix_beat_t  pix_data,

  input  logic                      wgt_valid,
  output logic                      wgt_ready,
  input  sa_stream_pkg::wgt_beat_t  wgt_data,

  input  logic                      tile_free,
  output logic                      step_en,
  output sa_stream_pkg::step_t      step,
  output logic                      tile_end
);

  logic last_beat;
  logic step_ok;

  // Tile ends only where both streams flag last
  assign last_beat = pix_data.last & wgt_data.last;

  // A last step waits for the drain buffer
  assign step_ok = pix_valid & wgt_valid & (~last_beat | tile_free);

  // Neither side moves without the other
  assign pix_ready = step_ok;
  assign wgt_ready = step_ok;
  assign step_en   = step_ok;

  always_comb begin
    step.pix  = pix_data.pix;
    step.wgt  = wgt_data.wgt;
    step.last = last_beat;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tile_end <= 1'b0;
    end else begin
      tile_end <= step_en & step.last;
    end
  end

endmodule

`default_nettype wire

/* rtl/sa_stream_pkg.sv */
`default_nettype none

package sa_stream_pkg;

  // Pixel stream, one value per row
  typedef struct packed {
    sa_geom_pkg::pix_t [sa_geom_pkg::R-1:0] pix;
    logic                                   last;
  } pix_beat_t;

  // Weight stream, one value per column
  typedef struct packed {
    sa_geom_pkg::wgt_t [sa_geom_pkg::C-1:0] wgt;
    logic                                   last;
  } wgt_beat_t;

  // Joined beat broadcast to every row
  typedef struct packed {
    sa_geom_pkg::pix_t [sa_geom_pkg::R-1:0] pix;
    sa_geom_pkg::wgt_t [sa_geom_pkg::C-1:0] wgt;
    logic                                   last;
  } step_t;

  // Partial sums added to one output column
  typedef struct packed {
    sa_geom_pkg::psum_t [sa_geom_pkg::R-1:0] psum;
  } psum_beat_t;

  // One output column, element r belongs to row r
  typedef struct packed {
    sa_geom_pkg::acc_t [sa_geom_pkg::R-1:0] data;
    logic                                   last;
  } out_beat_t;

endpackage

`default_nettype wire

/* rtl/sa_top.sv */
`default_nettype none

module sa_top (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       pix_valid,
  output logic                       pix_ready,
  input  sa_stream_pkg::pix_beat_t   pix_data,

  input  logic                       wgt_valid,
  output logic                       wgt_ready,
  input  sa_stream_pkg::wgt_beat_t   wgt_data,

  input  logic                       psum_valid,
  output logic                       psum_ready,
  input  sa_stream_pkg::psum_beat_t  psum_data,

  output logic                       out_valid,
  input  logic                       out_ready,
  output sa_stream_pkg::out_beat_t   out_data
);

  logic                      pix_s_valid;
  logic                      pix_s_ready;
  sa_stream_pkg::pix_beat_t  pix_s_data;
  logic                      wgt_s_valid;
  logic                      wgt_s_ready;
  sa_stream_pkg::wgt_beat_t  wgt_s_data;

  logic                      step_en;
  sa_stream_pkg::step_t      step;
  logic                      tile_end;
  logic                      tile_free;
  sa_geom_pkg::acc_row_t     row_acc [sa_geom_pkg::R];

  logic                      col_valid;
  logic                      col_ready;
  sa_stream_pkg::out_beat_t  col_data;

  // Input slices
  sa_skid_buffer #(.beat_t(sa_stream_pkg::pix_beat_t)) u_pix_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (pix_valid),
    .in_ready  (pix_ready),
    .in_data   (pix_data),
    .out_valid (pix_s_valid),
    .out_ready (pix_s_ready),
    .out_data  (pix_s_data)
  );

  sa_skid_buffer #(.beat_t(sa_stream_pkg::wgt_beat_t)) u_wgt_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (wgt_valid),
    .in_ready  (wgt_ready),
    .in_data   (wgt_data),
    .out_valid (wgt_s_valid),
    .out_ready (wgt_s_ready),
    .out_data  (wgt_s_data)
  );

  sa_stream_join u_join (
    .clk       (clk),
    .rst_n     (rst_n),
    .pix_valid (pix_s_valid),
    .pix_ready (pix_s_ready),
    .pix_data  (pix_s_data),
    .wgt_valid (wgt_s_valid),
    .wgt_ready (wgt_s_ready),
    .wgt_data  (wgt_s_data),
    .tile_free (tile_free),
    .step_en   (step_en),
    .step      (step),
    .tile_end  (tile_end)
  );

  // One row of accumulators per pixel lane
  for (genvar r = 0; r < sa_geom_pkg::R; r++) begin : g_row
    sa_mac_row #(.ROW(r)) u_row (
      .clk     (clk),
      .rst_n   (rst_n),
      .step_en (step_en),
      .step    (step),
      .acc     (row_acc[r])
    );
  end

  sa_drain u_drain (
    .clk        (clk),
    .rst_n      (rst_n),
    .tile_end   (tile_end),
    .row_acc    (row_acc),
    .tile_free  (tile_free),
    .psum_valid (psum_valid),
    .psum_ready (psum_ready),
    .psum_data  (psum_data),
    .out_valid  (col_valid),
    .out_ready  (col_ready),
    .out_data   (col_data)
  );

  // Output slice
  sa_skid_buffer #(.beat_t(sa_stream_pkg::out_beat_t)) u_out_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (col_valid),
    .in_ready  (col_ready),
    .in_data   (col_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

endmodule

`default_nettype wire

/* sa_accel.f */
rtl/sa_geom_pkg.sv
rtl/sa_stream_pkg.sv
rtl/sa_skid_buffer.sv
rtl/sa_stream_join.sv
rtl/sa_mac_row.sv
rtl/sa_drain.sv
rtl/sa_top.sv
bench/sa_top_sva.sv
bench/tb_sa_top.sv
